//--- flist.f
verilog/mem_pkg.sv
verilog/addr_split.sv
verilog/bank_map.sv
verilog/port_steer.sv
verilog/sp_bank.sv
verilog/read_mux.sv
verilog/mem_1r1w_top.sv
verification/mem_1r1w_sva.sv
verification/mem_1r1w_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module mem_1r1w_tb -o sim_mem
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_mem)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with an error status"
  exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1

//--- verification/mem_1r1w_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_1r1w_sva (
  input logic                         clk,
  input logic                         rst,
  input logic                         read,
  input logic                         write,
  input mem_pkg::addr_t               rd_addr,
  input mem_pkg::addr_t               wr_addr,
  input mem_pkg::pbank_t              rd_pbank,
  input mem_pkg::pbank_t              wr_pbank,
  input mem_pkg::pbank_t              map_q [mem_pkg::NUM_VROW][mem_pkg::NUM_VBNK],
  input logic [mem_pkg::NUM_PBNK-1:0] rd_hit,
  input logic [mem_pkg::NUM_PBNK-1:0] wr_hit
);
  import mem_pkg::*;

  logic map_ok;  // No row holds a physical bank twice

  always_comb begin
    map_ok = 1'b1;
    for (int r = 0; r < NUM_VROW; r++) begin
      for (int a = 0; a < NUM_VBNK; a++) begin
        for (int b = a + 1; b < NUM_VBNK; b++) begin
          if (map_q[r][a] == map_q[r][b]) begin
            map_ok = 1'b0;
          end
        end
      end
    end
  end

  a_rd_addr: assert property (@(posedge clk) disable iff (rst)
    read |-> rd_addr < addr_t'(NUM_ADDR)) else $error("read address out of range");

  a_wr_addr: assert property (@(posedge clk) disable iff (rst)
    write |-> wr_addr < addr_t'(NUM_ADDR)) else $error("write address out of range");

  // Write steered away from the bank being read
  a_redirect: assert property (@(posedge clk) disable iff (rst)
    read && write |-> rd_pbank != wr_pbank) else $error("write bank equals read bank");

  a_map_unique: assert property (@(posedge clk) disable iff (rst)
    map_ok) else $error("map table row holds one physical bank twice");

  a_one_access: assert property (@(posedge clk) disable iff (rst)
    (rd_hit & wr_hit) == '0) else $error("bank read and written in one cycle");

endmodule

bind mem_1r1w_top mem_1r1w_sva u_sva (
  .clk      (clk),
  .rst      (rst),
  .read     (read),
  .write    (write),
  .rd_addr  (rd_addr),
  .wr_addr  (wr_addr),
  .rd_pbank (rd_pbank),
  .wr_pbank (wr_pbank),
  .map_q    (u_map.map_q),
  .rd_hit   (u_steer.rd_hit),
  .wr_hit   (u_steer.wr_hit)
);

`default_nettype wire

//--- verification/mem_1r1w_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_1r1w_tb;
  import mem_pkg::*;

  localparam int TIMEOUT  = 20;   // Cycles to wait for rd_vld
  localparam int NUM_RAND = 500;

  logic  clk;
  logic  rst;
  logic  read;
  logic  write;
  addr_t rd_addr;
  addr_t wr_addr;
  data_t din;
  logic  rd_vld;
  data_t rd_dout;

  data_t ref_mem [NUM_ADDR];  // Reference model of the memory
  logic  pend_vld;            // Read issued in the last cycle
  addr_t pend_addr;
  data_t pend_data;
  int    seed;
  int    checks;
  int    errors;
  int    timeouts;

  mem_1r1w_top UUT (
    .clk     (clk),
    .rst     (rst),
    .read    (read),
    .write   (write),
    .rd_addr (rd_addr),
    .wr_addr (wr_addr),
    .din     (din),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout)
  );

  always #10 clk = ~clk;

  task automatic check_equal(input data_t got, input data_t exp, input string msg);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
    end
  endtask

  // Checks last cycle's read and drives this cycle's requests
  task automatic drive_cycle(input logic do_rd, input addr_t ra, input logic do_wr,
                             input addr_t wa, input data_t wd);
    check_equal(data_t'(rd_vld), data_t'(pend_vld), "rd_vld");
    if (pend_vld) begin
      check_equal(rd_dout, pend_data, $sformatf("read of address %0d", pend_addr));
    end
    pend_vld  = do_rd;
    pend_addr = ra;
    pend_data = ref_mem[ra];  // Old word before this cycle's write
    if (do_wr) begin
      ref_mem[wa] = wd;
    end
    read    = do_rd;
    rd_addr = ra;
    write   = do_wr;
    wr_addr = wa;
    din     = wd;
    @(negedge clk);
  endtask

  task automatic idle_cycle();
    drive_cycle(1'b0, '0, 1'b0, '0, '0);
  endtask

  task automatic read_and_check(input addr_t addr);
    int wait_cnt;
    wait_cnt = 0;
    read    = 1'b1;
    write   = 1'b0;
    rd_addr = addr;
    @(negedge clk);
    read = 1'b0;
    while (!rd_vld && wait_cnt < TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!rd_vld) begin
      timeouts++;
      $display("Timeout: no rd_vld after the read of address %0d", addr);
    end else begin
      check_equal(data_t'(wait_cnt), '0, "extra read latency");
      check_equal(rd_dout, ref_mem[addr], $sformatf("read back of address %0d", addr));
    end
    @(negedge clk);
  endtask

  task automatic apply_reset();
    rst      = 1'b1;
    read     = 1'b0;
    write    = 1'b0;
    rd_addr  = '0;
    wr_addr  = '0;
    din      = '0;
    pend_vld = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic idle_after_reset();
    repeat (4) idle_cycle();  // rd_vld must stay low
  endtask

  task automatic fill_and_read_back();
    for (int a = 0; a < NUM_ADDR; a++) begin
      drive_cycle(1'b0, '0, 1'b1, addr_t'(a), data_t'(32'h5a00 + a * 32'h0123));
    end
    for (int a = 0; a < NUM_ADDR; a++) begin
      read_and_check(addr_t'(a));
    end
  endtask

  // Read and write share one bank three times in row 9
  task automatic conflict_redirect();
    addr_t rd_list [3];
    addr_t wr_list [3];
    rd_list = '{addr_t'(5), addr_t'(17), addr_t'(33)};
    wr_list = '{addr_t'(9), addr_t'(25), addr_t'(41)};
    for (int i = 0; i < 3; i++) begin
      drive_cycle(1'b1, rd_list[i], 1'b1, wr_list[i], data_t'($random(seed)));
      drive_cycle(1'b1, wr_list[i], 1'b0, '0, '0);
      for (int j = 0; j < 3; j++) begin
        drive_cycle(1'b1, wr_list[j], 1'b0, '0, '0);
      end
    end
    idle_cycle();
  endtask

  task automatic same_addr_read_write();
    drive_cycle(1'b1, addr_t'(20), 1'b1, addr_t'(20), 16'hbeef);
    drive_cycle(1'b1, addr_t'(20), 1'b0, '0, '0);
    idle_cycle();
  endtask

  task automatic back_to_back_reads();
    for (int a = 0; a < NUM_ADDR; a++) begin
      drive_cycle(1'b1, addr_t'(a), 1'b0, '0, '0);
    end
    idle_cycle();
  endtask

  task automatic random_traffic();
    logic [31:0] r;
    addr_t       ra;
    addr_t       wa;
    for (int i = 0; i < NUM_RAND; i++) begin
      r  = $random(seed);
      ra = addr_t'({24'b0, r[15:8]} % NUM_ADDR);
      wa = addr_t'({24'b0, r[23:16]} % NUM_ADDR);
      drive_cycle(r[0] | r[1], ra, r[2] | r[3], wa, data_t'($random(seed)));
    end
    idle_cycle();
  endtask

  initial begin
    clk      = 1'b0;
    seed     = 32'h37cc;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    apply_reset();
    idle_after_reset();
    fill_and_read_back();
    conflict_redirect();
    same_addr_read_write();
    back_to_back_reads();
    random_traffic();
    $display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/addr_split.sv
`timescale 1ns/1ps
`default_nettype none

module addr_split (
  input  mem_pkg::addr_t  addr,
  output mem_pkg::vbank_t vbank,
  output mem_pkg::row_t   row
);
  import mem_pkg::*;

  addr_t base;  // First address of the selected bank

  // Compare chain on bank boundaries, no power of two needed
  always_comb begin
    vbank = '0;
    base  = '0;
    for (int v = 1; v < NUM_VBNK; v++) begin
      if (addr >= addr_t'(v * NUM_VROW)) begin
        vbank = vbank_t'(v);
        base  = addr_t'(v * NUM_VROW);
      end
    end
  end

  assign row = row_t'(addr - base);

endmodule

`default_nettype wire

//--- verilog/bank_map.sv
`timescale 1ns/1ps
`default_nettype none

module bank_map (
  input  logic            clk,
  input  logic            rst,
  input  logic            read,
  input  logic            write,
  input  mem_pkg::vbank_t rd_vbank,
  input  mem_pkg::vbank_t wr_vbank,
  input  mem_pkg::row_t   rd_row,
  input  mem_pkg::row_t   wr_row,
  output mem_pkg::pbank_t rd_pbank,
  output mem_pkg::pbank_t wr_pbank
);
  import mem_pkg::*;

  // Physical bank holding each virtual bank, per row
  pbank_t map_q [NUM_VROW][NUM_VBNK];

  pbank_t              wr_cur;      // Where the written word lives now
  pbank_t              free_pbank;  // Unused bank of the write row
  logic [NUM_PBNK-1:0] used;
  logic                conflict;

  assign rd_pbank = map_q[rd_row][rd_vbank];
  assign wr_cur   = map_q[wr_row][wr_vbank];

  // Exactly one bank per row is left over
  always_comb begin
    used = '0;
    for (int v = 0; v < NUM_VBNK; v++) begin
      used[map_q[wr_row][v]] = 1'b1;
    end
    free_pbank = '0;
    for (int p = NUM_PBNK - 1; p >= 0; p--) begin
      if (!used[p]) begin
        free_pbank = pbank_t'(p);
      end
    end
  end

  // Read owns the bank, write moves away
  assign conflict = read && write && (rd_pbank == wr_cur);
  assign wr_pbank = conflict ? free_pbank : wr_cur;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < NUM_VROW; r++) begin
        for (int v = 0; v < NUM_VBNK; v++) begin
          map_q[r][v] <= pbank_t'(v);  // Identity map, last bank free
        end
      end
    end else if (conflict) begin
      // Old bank of this entry becomes the row's free bank
      map_q[wr_row][wr_vbank] <= free_pbank;
    end
  end

endmodule

`default_nettype wire

//--- verilog/mem_1r1w_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_1r1w_top (
  input  logic           clk,
  input  logic           rst,
  input  logic           read,
  input  logic           write,
  input  mem_pkg::addr_t rd_addr,
  input  mem_pkg::addr_t wr_addr,
  input  mem_pkg::data_t din,
  output logic           rd_vld,
  output mem_pkg::data_t rd_dout
);
  import mem_pkg::*;

  vbank_t rd_vbank;
  vbank_t wr_vbank;
  row_t   rd_row;
  row_t   wr_row;
  pbank_t rd_pbank;
  pbank_t wr_pbank;

  logic [NUM_PBNK-1:0] bank_en;
  logic [NUM_PBNK-1:0] bank_we;
  row_t                bank_row  [NUM_PBNK];
  data_t               bank_din  [NUM_PBNK];
  data_t               bank_dout [NUM_PBNK];

  addr_split u_rd_split (
    .addr  (rd_addr),
    .vbank (rd_vbank),
    .row   (rd_row)
  );

  addr_split u_wr_split (
    .addr  (wr_addr),
    .vbank (wr_vbank),
    .row   (wr_row)
  );

  bank_map u_map (
    .clk      (clk),
    .rst      (rst),
    .read     (read),
    .write    (write),
    .rd_vbank (rd_vbank),
    .wr_vbank (wr_vbank),
    .rd_row   (rd_row),
    .wr_row   (wr_row),
    .rd_pbank (rd_pbank),
    .wr_pbank (wr_pbank)
  );

  port_steer u_steer (
    .read     (read),
    .write    (write),
    .rd_pbank (rd_pbank),
    .wr_pbank (wr_pbank),
    .rd_row   (rd_row),
    .wr_row   (wr_row),
    .din      (din),
    .bank_en  (bank_en),
    .bank_we  (bank_we),
    .bank_row (bank_row),
    .bank_din (bank_din)
  );

  // Three data banks plus the spare
  for (genvar b = 0; b < NUM_PBNK; b++) begin : g_bank
    sp_bank u_bank (
      .clk  (clk),
      .en   (bank_en[b]),
      .we   (bank_we[b]),
      .row  (bank_row[b]),
      .din  (bank_din[b]),
      .dout (bank_dout[b])
    );
  end

  read_mux u_read_mux (
    .clk       (clk),
    .rst       (rst),
    .read      (read),
    .rd_pbank  (rd_pbank),
    .bank_dout (bank_dout),
    .rd_vld    (rd_vld),
    .rd_dout   (rd_dout)
  );

endmodule

`default_nettype wire

//--- verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

  // Memory geometry
  localparam int WIDTH     = 16;
  localparam int NUM_ADDR  = 48;
  localparam int NUM_VBNK  = 3;
  localparam int NUM_PBNK  = NUM_VBNK + 1;  // One spare bank
  localparam int NUM_VROW  = 16;

  localparam int ADDR_BITS = 6;
  localparam int VBNK_BITS = 2;
  localparam int PBNK_BITS = 2;
  localparam int ROW_BITS  = 4;

  // Logical address, below NUM_ADDR
  typedef logic [ADDR_BITS-1:0] addr_t;

  // Virtual bank, 0 to NUM_VBNK-1
  typedef logic [VBNK_BITS-1:0] vbank_t;

  // Physical bank, 0 to NUM_PBNK-1
  typedef logic [PBNK_BITS-1:0] pbank_t;

  // Row within a bank
  typedef logic [ROW_BITS-1:0] row_t;

  typedef logic [WIDTH-1:0] data_t;

endpackage

`default_nettype wire

//--- verilog/port_steer.sv
`timescale 1ns/1ps
`default_nettype none

module port_steer (
  input  logic                         read,
  input  logic                         write,
  input  mem_pkg::pbank_t              rd_pbank,
  input  mem_pkg::pbank_t              wr_pbank,
  input  mem_pkg::row_t                rd_row,
  input  mem_pkg::row_t                wr_row,
  input  mem_pkg::data_t               din,
  output logic [mem_pkg::NUM_PBNK-1:0] bank_en,
  output logic [mem_pkg::NUM_PBNK-1:0] bank_we,
  output mem_pkg::row_t                bank_row [mem_pkg::NUM_PBNK],
  output mem_pkg::data_t               bank_din [mem_pkg::NUM_PBNK]
);
  import mem_pkg::*;

  logic [NUM_PBNK-1:0] rd_hit;
  logic [NUM_PBNK-1:0] wr_hit;

  always_comb begin
    for (int b = 0; b < NUM_PBNK; b++) begin
      rd_hit[b] = read && (rd_pbank == pbank_t'(b));
      wr_hit[b] = write && (wr_pbank == pbank_t'(b));
    end
  end

  // One access per bank, the map keeps rd_hit and wr_hit apart
  always_comb begin
    for (int b = 0; b < NUM_PBNK; b++) begin
      bank_en[b]  = rd_hit[b] || wr_hit[b];
      bank_we[b]  = wr_hit[b];
      bank_row[b] = wr_hit[b] ? wr_row : rd_row;
      bank_din[b] = wr_hit[b] ? din : '0;  // Quiet data on idle banks
    end
  end

endmodule

`default_nettype wire

//--- verilog/read_mux.sv
`timescale 1ns/1ps
`default_nettype none

module read_mux (
  input  logic            clk,
  input  logic            rst,
  input  logic            read,
  input  mem_pkg::pbank_t rd_pbank,
  input  mem_pkg::data_t  bank_dout [mem_pkg::NUM_PBNK],
  output logic            rd_vld,
  output mem_pkg::data_t  rd_dout
);
  import mem_pkg::*;

  pbank_t rd_sel_q;  // Bank read last cycle

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_vld <= 1'b0;
    end else begin
      rd_vld <= read;
    end
  end

  always_ff @(posedge clk) begin
    if (read) begin
      rd_sel_q <= rd_pbank;
    end
  end

  // Bank dout is already registered, so select directly
  assign rd_dout = bank_dout[rd_sel_q];

endmodule

`default_nettype wire

//--- verilog/sp_bank.sv
`timescale 1ns/1ps
`default_nettype none

module sp_bank (
  input  logic           clk,
  input  logic           en,
  input  logic           we,
  input  mem_pkg::row_t  row,
  input  mem_pkg::data_t din,
  output mem_pkg::data_t dout
);
  import mem_pkg::*;

  data_t mem [NUM_VROW];

  // Single port, write or read per cycle
  always_ff @(posedge clk) begin
    if (en) begin
      if (we) begin
        mem[row] <= din;
      end else begin
        dout <= mem[row];  // Held until the next read
      end
    end
  end

endmodule

`default_nettype wire
